//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := l2_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/l2_bus_pkg.sv
package l2_bus_pkg;

    import l2_geom_pkg::*;

    // ============================
    // Upstream request, 161 bits
    // ============================
    typedef struct packed {
        logic  wr;    // 1 = line write, 0 = line read
        addr_t addr;  // Any byte inside the line
        line_t wline; // Line to store, ignored on reads
    } l2_req_t;

    // ============================
    // Memory command, 161 bits
    // ============================
    typedef struct packed {
        logic  wr;   // 1 = write back a victim
        addr_t addr; // Always line aligned
        line_t line; // Victim line on writes, zero on reads
    } mem_cmd_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE      = 2'd0, // Waiting for a request
        LOOKUP    = 2'd1, // Tag compare on the set read last cycle
        WRITEBACK = 2'd2, // Dirty victim going out to memory
        REFILL    = 2'd3  // Line fetch for a read miss
    } ctrl_state_e;

endpackage

//--- hw/l2_cache_top.sv
module l2_cache_top import l2_geom_pkg::*, l2_bus_pkg::*; #(
    parameter int N_SETS = 64 // Power of two
) (
    input  logic     clk_i,
    input  logic     rst_i,
    // Upstream
    input  logic     req_valid_i,
    input  l2_req_t  req_i,
    output logic     resp_ready_o,
    output line_t    resp_line_o,
    // Main memory
    output logic     mem_valid_o,
    output mem_cmd_t mem_cmd_o,
    input  logic     mem_ready_i,
    input  line_t    mem_line_i
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFFS_W;

    // ============================
    // Internal wiring
    // ============================
    logic [TAG_W-1:0]  tag, victim_tag;
    logic [IDX_W-1:0]  index;
    addr_t             line_base;
    logic              is_write, accept;
    line_t             wline, hit_line, victim_line, data_line;
    logic              hit, victim_valid, victim_dirty;
    way_t              hit_way, victim_way;
    logic [N_WAYS-1:0] tag_we, data_we;
    logic              valid_d, dirty_d, fifo_adv;

    l2_req_decode #(.N_SETS(N_SETS)) u_decode (
        .clk_i, .rst_i, .req_valid_i, .req_i,
        .accept_i    (accept),
        .tag_o       (tag),
        .index_o     (index),
        .line_base_o (line_base),
        .is_write_o  (is_write),
        .wline_o     (wline)
    );

    l2_tag_store #(.N_SETS(N_SETS)) u_tags (
        .clk_i, .rst_i,
        .index_i        (index),
        .tag_i          (tag),
        .we_i           (tag_we),
        .valid_d_i      (valid_d),
        .dirty_d_i      (dirty_d),
        .fifo_adv_i     (fifo_adv),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_valid_o (victim_valid),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    l2_data_store #(.N_SETS(N_SETS)) u_data (
        .clk_i,
        .index_i       (index),
        .we_i          (data_we),
        .line_i        (data_line),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .hit_line_o    (hit_line),
        .victim_line_o (victim_line)
    );

    l2_ctrl #(.N_SETS(N_SETS)) u_ctrl (
        .clk_i, .rst_i, .req_valid_i,
        .is_write_i     (is_write),
        .wline_i        (wline),
        .line_base_i    (line_base),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_valid_i (victim_valid),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .hit_line_i     (hit_line),
        .victim_line_i  (victim_line),
        .index_i        (index),
        .mem_ready_i, .mem_line_i,
        .accept_o       (accept),
        .tag_we_o       (tag_we),
        .valid_d_o      (valid_d),
        .dirty_d_o      (dirty_d),
        .fifo_adv_o     (fifo_adv),
        .data_we_o      (data_we),
        .data_line_o    (data_line),
        .resp_ready_o, .resp_line_o, .mem_valid_o, .mem_cmd_o
    );

endmodule

//--- hw/l2_ctrl.sv
module l2_ctrl import l2_geom_pkg::*, l2_bus_pkg::*; #(
    parameter int N_SETS = 64
) (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   req_valid_i,
    input  logic                                   is_write_i,
    input  line_t                                  wline_i,
    input  addr_t                                  line_base_i,
    input  logic                                   hit_i,
    input  way_t                                   hit_way_i,
    input  way_t                                   victim_way_i,
    input  logic                                   victim_valid_i,
    input  logic                                   victim_dirty_i,
    input  logic [ADDR_W-$clog2(N_SETS)-OFFS_W-1:0] victim_tag_i,
    input  line_t                                  hit_line_i,
    input  line_t                                  victim_line_i,
    input  logic [$clog2(N_SETS)-1:0]              index_i,
    input  logic                                   mem_ready_i,
    input  line_t                                  mem_line_i,
    output logic                                   accept_o,
    output logic [N_WAYS-1:0]                      tag_we_o,
    output logic                                   valid_d_o,
    output logic                                   dirty_d_o,
    output logic                                   fifo_adv_o,
    output logic [N_WAYS-1:0]                      data_we_o,
    output line_t                                  data_line_o,
    output logic                                   resp_ready_o,
    output line_t                                  resp_line_o,
    output logic                                   mem_valid_o,
    output mem_cmd_t                               mem_cmd_o
);

    localparam logic [N_WAYS-1:0] WAY0 = {{(N_WAYS-1){1'b0}}, 1'b1};

    ctrl_state_e state_q, state_d;

    logic  hit_done;    // Hit answered in LOOKUP
    logic  wr_alloc;    // Write miss installs its own line
    logic  rd_fill;     // Refill data arrives
    logic  alloc;       // Any allocation into the victim way
    logic  evict;       // Victim must go out first
    addr_t victim_base; // Line address of the victim

    assign evict       = victim_valid_i && victim_dirty_i;
    assign victim_base = {victim_tag_i, index_i, {OFFS_W{1'b0}}};

    // ============================
    // FSM
    // ============================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) state_d = LOOKUP; // Stores read the set now
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = IDLE;
                end else if (evict) begin
                    state_d = WRITEBACK;
                end else if (is_write_i) begin
                    state_d = IDLE;      // Full line, nothing to fetch
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                if (mem_ready_i) state_d = is_write_i ? IDLE : REFILL;
            end
            REFILL: begin
                if (mem_ready_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    assign accept_o = (state_q == IDLE) && req_valid_i;

    // ============================
    // Store updates
    // ============================
    assign hit_done = (state_q == LOOKUP) && hit_i;
    assign wr_alloc = is_write_i && (((state_q == LOOKUP) && !hit_i && !evict) ||
                                     ((state_q == WRITEBACK) && mem_ready_i));
    assign rd_fill  = (state_q == REFILL) && mem_ready_i;
    assign alloc    = wr_alloc || rd_fill;

    always_comb begin
        tag_we_o = '0;
        if (alloc) begin
            tag_we_o = WAY0 << victim_way_i;     // Replace the FIFO victim
        end else if (hit_done && is_write_i) begin
            tag_we_o = WAY0 << hit_way_i;        // Same tag, now dirty
        end
    end

    assign valid_d_o   = |tag_we_o;              // Every write leaves the way valid
    assign dirty_d_o   = is_write_i;             // Refills come in clean
    assign fifo_adv_o  = alloc;
    assign data_we_o   = tag_we_o;
    assign data_line_o = rd_fill ? mem_line_i : wline_i;

    // ============================
    // Response side
    // ============================
    assign resp_ready_o = hit_done || alloc;

    always_comb begin
        resp_line_o = '0;
        if (hit_done && !is_write_i) begin
            resp_line_o = hit_line_i;
        end else if (rd_fill) begin
            resp_line_o = mem_line_i; // Forwarded while it is installed
        end
    end

    // ============================
    // Memory side
    // ============================
    assign mem_valid_o = ((state_q == WRITEBACK) || (state_q == REFILL)) && !mem_ready_i;

    always_comb begin
        mem_cmd_o = '0;
        case (state_q)
            WRITEBACK: begin
                mem_cmd_o.wr   = 1'b1;
                mem_cmd_o.addr = victim_base;
                mem_cmd_o.line = victim_line_i; // Store output, held by the index
            end
            REFILL: begin
                mem_cmd_o.addr = line_base_i;
            end
            default: ;
        endcase
    end

    // Stores and decode must keep the command steady under back-pressure
    a_cmd_stable : assert property (@(posedge clk_i) disable iff (rst_i)
        mem_valid_o |=> $stable(mem_cmd_o));

endmodule

//--- hw/l2_data_store.sv
module l2_data_store import l2_geom_pkg::*; #(
    parameter int N_SETS = 64
) (
    input  logic                      clk_i,
    input  logic [$clog2(N_SETS)-1:0] index_i,
    input  logic [N_WAYS-1:0]         we_i,        // One-hot way write
    input  line_t                     line_i,
    input  way_t                      hit_way_i,
    input  way_t                      victim_way_i,
    output line_t                     hit_line_o,
    output line_t                     victim_line_o
);

    line_t rd_q [N_WAYS]; // Registered read of all four ways

    // ============================
    // One line array per way
    // ============================
    for (genvar w = 0; w < N_WAYS; w++) begin : g_way
        line_t mem [N_SETS];

        always_ff @(posedge clk_i) begin
            if (we_i[w]) begin
                mem[index_i] <= line_i;
            end
            rd_q[w] <= mem[index_i]; // Old data on a same-cycle write
        end
    end

    // Way select after the read
    assign hit_line_o    = rd_q[hit_way_i];
    assign victim_line_o = rd_q[victim_way_i]; // Write-back payload

endmodule

//--- hw/l2_geom_pkg.sv
package l2_geom_pkg;

    // ============================
    // Cache geometry
    // ============================
    localparam int ADDR_W = 32;                // Byte address width
    localparam int LINE_W = 128;               // One line, 16 bytes
    localparam int N_WAYS = 4;                 // Fixed, FIFO counter width depends on it
    localparam int WAY_W  = $clog2(N_WAYS);    // Bits to name a way
    localparam int OFFS_W = $clog2(LINE_W / 8); // Byte offset inside a line

    // ============================
    // Width types
    // ============================
    typedef logic [ADDR_W-1:0] addr_t; // Byte address
    typedef logic [LINE_W-1:0] line_t; // Whole cache line
    typedef logic [WAY_W-1:0]  way_t;  // Way number 0..3

endpackage

//--- hw/l2_req_decode.sv
module l2_req_decode import l2_geom_pkg::*, l2_bus_pkg::*; #(
    parameter int N_SETS = 64
) (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic                                   req_valid_i,
    input  l2_req_t                                req_i,
    input  logic                                   accept_i,    // Controller takes req_i now
    output logic [ADDR_W-$clog2(N_SETS)-OFFS_W-1:0] tag_o,
    output logic [$clog2(N_SETS)-1:0]              index_o,
    output addr_t                                  line_base_o,
    output logic                                   is_write_o,
    output line_t                                  wline_o
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFFS_W;

    l2_req_t req_q;   // Held request valid until the response
    l2_req_t req_cur; // What the stores and controller see this cycle
    logic    take;

    assign take = accept_i & req_valid_i;

    // Capture on accept and hold until the response
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q.wr   <= 1'b0;
            req_q.addr <= '0;
        end else if (take) begin
            req_q <= req_i;
        end
    end

    // Bypass in the accept cycle so the set read starts at once
    assign req_cur = take ? req_i : req_q;

    // ============================
    // Address split
    // ============================
    assign tag_o       = req_cur.addr[ADDR_W-1 -: TAG_W];      // Upper bits
    assign index_o     = req_cur.addr[OFFS_W +: IDX_W];        // Set select
    assign line_base_o = {req_cur.addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}}; // Offset dropped
    assign is_write_o  = req_cur.wr;
    assign wline_o     = req_cur.wline;

endmodule

//--- hw/l2_tag_store.sv
module l2_tag_store import l2_geom_pkg::*; #(
    parameter int N_SETS = 64
) (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  logic [$clog2(N_SETS)-1:0]              index_i,
    input  logic [ADDR_W-$clog2(N_SETS)-OFFS_W-1:0] tag_i,
    input  logic [N_WAYS-1:0]                      we_i,        // One-hot way write
    input  logic                                   valid_d_i,
    input  logic                                   dirty_d_i,
    input  logic                                   fifo_adv_i,  // Allocation in this set
    output logic                                   hit_o,
    output way_t                                   hit_way_o,
    output way_t                                   victim_way_o,
    output logic                                   victim_valid_o,
    output logic                                   victim_dirty_o,
    output logic [ADDR_W-$clog2(N_SETS)-OFFS_W-1:0] victim_tag_o
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = ADDR_W - IDX_W - OFFS_W;

    typedef logic [TAG_W-1:0] tag_t;

    // ============================
    // Storage
    // ============================
    tag_t              tag_mem   [N_SETS][N_WAYS];
    logic [N_WAYS-1:0] valid_mem [N_SETS]; // One bit per way
    logic [N_WAYS-1:0] dirty_mem [N_SETS];
    way_t              fifo_cnt  [N_SETS]; // Next victim of each set

    // Read side, one cycle behind index_i
    tag_t              tag_q [N_WAYS];
    logic [N_WAYS-1:0] valid_q;
    logic [N_WAYS-1:0] dirty_q;
    way_t              victim_q;
    logic [N_WAYS-1:0] way_hit;

    // Valid bits and FIFO counters come up cleared
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid_mem[s] <= '0;
                fifo_cnt[s]  <= '0;
            end
        end else begin
            for (int w = 0; w < N_WAYS; w++) begin
                if (we_i[w]) begin
                    valid_mem[index_i][w] <= valid_d_i;
                end
            end
            if (fifo_adv_i) begin
                fifo_cnt[index_i] <= fifo_cnt[index_i] + 1'b1; // Wraps 3 -> 0
            end
        end
    end

    // Tags and dirty bits follow the valid bit
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < N_WAYS; w++) begin
            if (we_i[w]) begin
                tag_mem[index_i][w]   <= tag_i;
                dirty_mem[index_i][w] <= dirty_d_i;
            end
        end
    end

    // Synchronous set read
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < N_WAYS; w++) begin
            tag_q[w] <= tag_mem[index_i][w];
        end
        valid_q  <= valid_mem[index_i];
        dirty_q  <= dirty_mem[index_i];
        victim_q <= fifo_cnt[index_i];
    end

    // ============================
    // Hit detection
    // ============================
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            way_hit[w] = valid_q[w] && (tag_q[w] == tag_i);
        end
    end

    assign hit_o = |way_hit;

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way_o = way_t'(w); // Only one can be set
            end
        end
    end

    // Victim fields for eviction
    assign victim_way_o   = victim_q;
    assign victim_valid_o = valid_q[victim_q];
    assign victim_dirty_o = dirty_q[victim_q];
    assign victim_tag_o   = tag_q[victim_q];

    // A line is never installed twice in one set
    a_single_hit : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(way_hit));

endmodule

//--- list.f
hw/l2_geom_pkg.sv
hw/l2_bus_pkg.sv
hw/l2_req_decode.sv
hw/l2_tag_store.sv
hw/l2_data_store.sv
hw/l2_ctrl.sv
hw/l2_cache_top.sv
verif/l2_mem_model.sv
verif/l2_tb.sv

//--- verif/l2_mem_model.sv
module l2_mem_model import l2_geom_pkg::*, l2_bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     mem_valid_i,
    input  mem_cmd_t mem_cmd_i,
    output logic     mem_ready_o,
    output line_t    mem_line_o
);

    line_t store [addr_t]; // Sparse, only lines that were written back

    // Never-written line, every word depends on the full address
    function automatic line_t fill_line(addr_t a);
        return {a ^ 32'hc3a5_5a3c, ~a, {a[15:0], a[31:16]}, a + 32'h0101_0101};
    endfunction

    // ==============================
    // Responder
    // ==============================
    initial begin
        mem_cmd_t cmd;
        int       lat;
        mem_ready_o = 1'b0;
        mem_line_o  = '0;
        forever begin
            @(posedge clk_i);                      // Values from before the edge
            if (!rst_i && mem_valid_i) begin
                cmd = mem_cmd_i;                   // First cycle of a new command
                lat = $urandom_range(1, 4);        // Cycles until ready
                repeat (lat - 1) @(posedge clk_i);
                @(negedge clk_i);
                if (cmd.wr) begin
                    store[cmd.addr] = cmd.line;    // Victim lands in memory
                end else if (store.exists(cmd.addr)) begin
                    mem_line_o = store[cmd.addr];
                end else begin
                    mem_line_o = fill_line(cmd.addr);
                end
                mem_ready_o = 1'b1;                // Single cycle pulse
                @(negedge clk_i);
                mem_ready_o = 1'b0;
                mem_line_o  = '0;
            end
        end
    end

endmodule

//--- verif/l2_tb.sv
module l2_tb import l2_geom_pkg::*, l2_bus_pkg::*; ();

    localparam int N_SETS     = 64;
    localparam int IDX_W      = $clog2(N_SETS);
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;
    localparam int N_DIRECTED = 16;   // Upper bound of the directed requests
    localparam int N_RAND     = 400;
    localparam int WDOG_CYC   = 2000 * (N_DIRECTED + N_RAND) + RST_CYCLES;

    logic     clk;
    logic     rst;
    logic     req_valid;
    l2_req_t  req;
    logic     resp_ready;
    line_t    resp_line;
    logic     mem_valid;
    mem_cmd_t mem_cmd;
    logic     mem_ready;
    line_t    mem_line;

    int err_cnt   = 0;
    int check_cnt = 0;
    int req_cnt   = 0;

    // Reference cache with FIFO order per set
    addr_t    ref_base  [N_SETS][N_WAYS];
    logic     ref_valid [N_SETS][N_WAYS];
    logic     ref_dirty [N_SETS][N_WAYS];
    line_t    ref_line  [N_SETS][N_WAYS];
    int       ref_fifo  [N_SETS];
    line_t    ref_mem   [addr_t];       // Lines written back so far
    mem_cmd_t exp_cmds  [$];            // Memory commands still due

    l2_cache_top #(.N_SETS(N_SETS)) u_dut (
        .clk_i (clk), .rst_i (rst), .req_valid_i (req_valid), .req_i (req),
        .resp_ready_o (resp_ready), .resp_line_o (resp_line),
        .mem_valid_o (mem_valid), .mem_cmd_o (mem_cmd),
        .mem_ready_i (mem_ready), .mem_line_i (mem_line)
    );

    l2_mem_model u_mem (
        .clk_i (clk), .rst_i (rst), .mem_valid_i (mem_valid), .mem_cmd_i (mem_cmd),
        .mem_ready_o (mem_ready), .mem_line_o (mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Memory contents of a line never written
    function automatic line_t mem_pattern(addr_t a);
        return {a ^ 32'hc3a5_5a3c, ~a, {a[15:0], a[31:16]}, a + 32'h0101_0101};
    endfunction

    function automatic addr_t compose_addr(int tag, int set, int offs);
        return (addr_t'(tag) << (IDX_W + OFFS_W)) | (addr_t'(set) << OFFS_W) | addr_t'(offs);
    endfunction

    // ==============================
    // Reference model
    // ==============================
    task automatic predict_access(input logic wr, input addr_t addr, input line_t wline,
                                  output line_t exp_line, output logic exp_hit);
        addr_t    base;
        int       set;
        int       way;
        mem_cmd_t cmd;
        base     = addr - (addr % (LINE_W / 8));        // Start of the 16-byte line
        set      = int'((base / (LINE_W / 8)) % N_SETS);
        way      = -1;
        exp_line = '0;                                  // Writes answer with zero
        for (int w = 0; w < N_WAYS; w++) begin
            if (ref_valid[set][w] && ref_base[set][w] == base) way = w;
        end
        exp_hit = (way >= 0);
        if (exp_hit && wr) begin
            ref_line[set][way]  = wline;
            ref_dirty[set][way] = 1'b1;
        end else if (exp_hit) begin
            exp_line = ref_line[set][way];
        end else begin
            way = ref_fifo[set];                        // Oldest allocation goes
            if (ref_valid[set][way] && ref_dirty[set][way]) begin
                cmd.wr   = 1'b1;
                cmd.addr = ref_base[set][way];
                cmd.line = ref_line[set][way];
                exp_cmds.push_back(cmd);
                ref_mem[cmd.addr] = cmd.line;
            end
            if (wr) begin
                ref_line[set][way] = wline;             // Full line needs no fetch
            end else begin
                cmd.wr   = 1'b0;
                cmd.addr = base;
                cmd.line = '0;
                exp_cmds.push_back(cmd);
                ref_line[set][way] = ref_mem.exists(base) ? ref_mem[base] : mem_pattern(base);
                exp_line = ref_line[set][way];
            end
            ref_base[set][way]  = base;
            ref_valid[set][way] = 1'b1;
            ref_dirty[set][way] = wr;
            ref_fifo[set]       = (way + 1) % N_WAYS;
        end
    endtask

    // Each valid cycle must show the command at the head of the queue
    task automatic check_mem_side();
        if (mem_valid) begin
            check_cnt++;
            assert (exp_cmds.size() != 0) else begin
                err_cnt++;
                $display("Unexpected memory command at %0t for address %h", $time, mem_cmd.addr);
            end
            if (exp_cmds.size() != 0) begin
                assert (mem_cmd == exp_cmds[0]) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: memory command %h, expected %h",
                             $time, mem_cmd, exp_cmds[0]);
                end
            end
        end
        if (mem_ready) begin
            check_cnt++;
            assert (!mem_valid) else begin
                err_cnt++;
                $display("Mismatch at %0t: memory valid still high in the ready cycle", $time);
            end
            if (exp_cmds.size() != 0) void'(exp_cmds.pop_front());
        end
    endtask

    task automatic expect_quiet();
        check_cnt++;
        assert (!resp_ready && !mem_valid && resp_line == '0) else begin
            err_cnt++;
            $display("Mismatch at %0t: response or memory side not quiet while idle", $time);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            expect_quiet();
        end
        @(negedge clk);
    endtask

    // Starts and ends on a falling edge
    task automatic run_request(input logic wr, input addr_t addr, input line_t wline);
        line_t exp_line;
        logic  exp_hit;
        int    n;
        logic  done;
        predict_access(wr, addr, wline, exp_line, exp_hit);
        req.wr    = wr;
        req.addr  = addr;
        req.wline = wline;
        req_valid = 1'b1;
        n         = 0;
        done      = 1'b0;
        while (!done) begin
            @(posedge clk);                    // First edge accepts since the DUT is in IDLE
            n++;
            check_mem_side();
            check_cnt++;
            if (resp_ready) begin
                done = 1'b1;
                assert (exp_cmds.size() == 0) else begin
                    err_cnt++;
                    $display("Response for %h at %0t came before %0d memory commands",
                             addr, $time, exp_cmds.size());
                end
                exp_cmds.delete();
                assert (resp_line == exp_line) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: line for %h is %h, expected %h",
                             $time, addr, resp_line, exp_line);
                end
                if (exp_hit) begin
                    assert (n == 2) else begin
                        err_cnt++;
                        $display("Mismatch at %0t: hit on %h answered %0d cycles after accept",
                                 $time, addr, n - 1);
                    end
                end
            end else begin
                assert (resp_line == '0) else begin
                    err_cnt++;
                    $display("Mismatch at %0t: response line not zero between answers", $time);
                end
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
        req_cnt++;
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        logic  wr;
        line_t wline;
        void'($urandom(32'hf981_3df3));       // Single seed for the run
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        for (int s = 0; s < N_SETS; s++) begin
            ref_fifo[s] = 0;
            for (int w = 0; w < N_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) expect_quiet();         // State is known from the second edge
        end
        @(negedge clk);
        rst = 1'b0;
        idle_cycles(4);
        // Cold read, then hits, a write hit and its read back
        run_request(1'b0, compose_addr(1, 0, 4), '0);
        run_request(1'b0, compose_addr(1, 0, 8), '0);
        run_request(1'b1, compose_addr(1, 0, 0), 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
        run_request(1'b0, compose_addr(1, 0, 12), '0);
        idle_cycles(2);
        // Write miss installs without a fetch
        run_request(1'b1, compose_addr(2, 1, 0), 128'hdead_beef_0000_1111_2222_3333_cafe_f00d);
        run_request(1'b0, compose_addr(2, 1, 12), '0);
        idle_cycles(2);
        // Fill set 5 and then evict dirty way 0 and clean ways 1 and 2
        run_request(1'b1, compose_addr(10, 5, 0), 128'h5555_aaaa_5555_aaaa_0f0f_f0f0_1234_8765);
        for (int t = 11; t <= 15; t++) run_request(1'b0, compose_addr(t, 5, t), '0);
        run_request(1'b0, compose_addr(10, 5, 8), '0);
        idle_cycles(2);
        // Random mix over 8 sets with 6 tags each to force evictions
        for (int i = 0; i < N_RAND; i++) begin
            wr    = ($urandom_range(0, 9) < 4);
            wline = {$urandom, $urandom, $urandom, $urandom};
            run_request(wr, compose_addr(32 + $urandom_range(0, 5), $urandom_range(0, 7),
                                         $urandom_range(0, 15)), wline);
            idle_cycles($urandom_range(0, 2));
        end
        idle_cycles(4);
        $display("Summary: %0d requests, %0d checks, %0d errors", req_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the cache stopped answering", WDOG_CYC);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
